// ==== cnn_pool_layer.f ====
+incdir+logic
logic/fp16_pkg.sv
logic/layer_pkg.sv
logic/fm_window_feeder.sv
logic/pool_lane.sv
logic/result_drain.sv
logic/cnn_pool_layer.sv
bench/cnn_pool_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pooling layer testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f cnn_pool_layer.f \
    --top-module cnn_pool_layer_tb \
    -o cnn_pool_layer_sim

output=$(./obj_dir/cnn_pool_layer_sim) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "TEST OK"

// ==== bench/cnn_pool_layer_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cnn_defines.svh"

module cnn_pool_layer_tb;
    import fp16_pkg::*;
    import layer_pkg::*;

    localparam int MODE_POSITIVE   = 0;
    localparam int MODE_MIXED      = 1;  // hand placed signs and zeros for 4x4 maps
    localparam int MODE_RANDOM     = 2;
    localparam int SEL_START_ACK   = 0;
    localparam int SEL_OUT_REQ     = 1;
    localparam int SEL_LAYER_READY = 2;
    localparam int WAIT_LIMIT      = 100;  // cycles per handshake step
    localparam int MAX_ACK_DELAY   = 7;
    localparam int TOTAL_WINDOWS   = 61;   // all layers below with the cut one counted in full
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_WINDOWS * (MAX_ACK_DELAY + 6);

    logic clk;
    logic rst;
    logic fm_wr_en;
    logic [`FM_SIZE_WIDTH-1:0] fm_wr_row;
    logic [`FM_SIZE_WIDTH-1:0] fm_wr_col;
    fm_pixel_t fm_wr_data;
    logic start_req;
    layer_cfg_t start_cfg;
    logic start_ack;
    logic layer_ready;
    logic out_req;
    logic out_ack;
    pool_result_t out_data;

    integer seed;
    int errors;
    int test_count;
    int failed_tests;
    int received;                                   // results taken in the current layer
    fm_pixel_t ref_map [`FM_SIZE_MAX][`FM_SIZE_MAX]; // copy of what was loaded
    pool_result_t exp_q [$];

    cnn_pool_layer uut (
        .clk         (clk),
        .rst         (rst),
        .fm_wr_en    (fm_wr_en),
        .fm_wr_row   (fm_wr_row),
        .fm_wr_col   (fm_wr_col),
        .fm_wr_data  (fm_wr_data),
        .start_req   (start_req),
        .start_cfg   (start_cfg),
        .start_ack   (start_ack),
        .layer_ready (layer_ready),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // total order of half words with -0 folded onto +0 and negatives reversed
    function automatic logic [15:0] order_key(input fp16_t v);
        logic [14:0] mag;
        mag = {v.fields.exponent, v.fields.mantissa};
        if (v.fields.sign && mag != '0)
            return {1'b0, ~mag};
        return {1'b1, mag};
    endfunction

    // 2x2 max in scan order tl tr bl br where the first of equal keys stays
    function automatic fp16_t pool_model(input fp16_t tl, input fp16_t tr,
                                         input fp16_t bl, input fp16_t br, input logic relu);
        fp16_t cand [4];
        fp16_t best;
        cand = '{tl, tr, bl, br};
        best = tl;
        for (int i = 1; i < 4; i++) begin
            if (order_key(cand[i]) > order_key(best))
                best = cand[i];
        end
        if (relu && best.fields.sign)
            best.raw = '0;  // any negative including -0
        return best;
    endfunction

    // window 0 all negative and window 1 signed zeros with alternating signs elsewhere
    function automatic fp16_t mixed_value(input int r, input int c, input int ch);
        fp16_t v;
        int win;
        int pos;
        win = (r / 2) * 2 + c / 2;
        pos = (r % 2) * 2 + c % 2;
        v.fields.exponent = 5'(8 + r + 2 * c + ch);
        v.fields.mantissa = 10'(37 * ch + 11 * pos + 3);
        v.fields.sign = 1'((r + c + ch) % 2);
        if (win == 0) begin
            v.fields.sign = 1'b1;
        end else if (win == 1) begin
            v.fields.sign = 1'b1;
            if (pos != 3) begin
                v.raw = '0;
                v.fields.sign = 1'((pos + ch + 1) % 2);  // odd channels start with +0
            end
        end
        return v;
    endfunction

    function automatic logic signal_level(input int sel);
        case (sel)
            SEL_START_ACK: return start_ack;
            SEL_OUT_REQ:   return out_req;
            default:       return layer_ready;
        endcase
    endfunction

    // polls on falling edges and gives up after WAIT_LIMIT
    task automatic wait_signal(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        while (signal_level(sel) !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (signal_level(sel) !== level) begin
            $display("timeout: %s did not go to %0b within %0d cycles", what, level, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_fp16(input string name, input fp16_t got, input fp16_t exp);
        if (got.raw !== exp.raw) begin
            $display("mismatch %s: got %h expected %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic compare_result(input pool_result_t got, input pool_result_t exp);
        if (got.out_row !== exp.out_row || got.out_col !== exp.out_col) begin
            $display("mismatch out_data position: got %h,%h expected %h,%h",
                     got.out_row, got.out_col, exp.out_row, exp.out_col);
            errors++;
        end
        for (int l = 0; l < `PARA_LANES; l++)
            compare_fp16($sformatf("out_data.values[%0d]", l), got.values[l], exp.values[l]);
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s count: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_fm(input int size, input int mode);
        fm_pixel_t px;
        integer word;
        for (int r = 0; r < size; r++) begin
            for (int c = 0; c < size; c++) begin
                for (int ch = 0; ch < `PARA_LANES; ch++) begin
                    word = $random(seed);
                    if (mode == MODE_MIXED)
                        px[ch] = mixed_value(r, c, ch);
                    else
                        px[ch].raw = word[15:0];
                    if (mode == MODE_POSITIVE) begin
                        px[ch].fields.sign = 1'b0;
                        px[ch].fields.exponent = 5'($unsigned(word) % 31);  // stays finite
                    end
                end
                ref_map[r][c] = px;
                @(negedge clk);
                fm_wr_en   = 1'b1;
                fm_wr_row  = 3'(r);
                fm_wr_col  = 3'(c);
                fm_wr_data = px;
            end
        end
        @(negedge clk);
        fm_wr_en = 1'b0;
    endtask

    task automatic make_expected(input int size, input logic relu);
        pool_result_t e;
        exp_q.delete();
        for (int orow = 0; orow < size / 2; orow++) begin
            for (int ocol = 0; ocol < size / 2; ocol++) begin  // row major as issued
                e.out_row = 2'(orow);
                e.out_col = 2'(ocol);
                for (int l = 0; l < `PARA_LANES; l++)
                    e.values[l] = pool_model(ref_map[2*orow][2*ocol][l],
                                             ref_map[2*orow][2*ocol+1][l],
                                             ref_map[2*orow+1][2*ocol][l],
                                             ref_map[2*orow+1][2*ocol+1][l], relu);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic start_layer(input int size, input logic relu);
        @(negedge clk);
        start_cfg.fm_size = 4'(size);
        start_cfg.relu_en = relu;
        start_req = 1'b1;
        wait_signal(SEL_START_ACK, 1'b1, "start_ack");
        compare_bit("layer_ready", layer_ready, 1'b0);  // dropped on the ack edge
        start_req = 1'b0;
        wait_signal(SEL_START_ACK, 1'b0, "start_ack");
    endtask

    task automatic collect_outputs(input int max_delay);
        pool_result_t got;
        int delay;
        received = 0;
        foreach (exp_q[i]) begin
            wait_signal(SEL_OUT_REQ, 1'b1, "out_req");
            if (out_req !== 1'b1)
                return;  // the request never came
            got = out_data;
            compare_result(got, exp_q[i]);
            compare_bit("layer_ready", layer_ready, 1'b0); // busy until the last ack
            received++;
            delay = $unsigned($random(seed)) % (max_delay + 1);
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_signal(SEL_OUT_REQ, 1'b0, "out_req");
            out_ack = 1'b0;
        end
        wait_signal(SEL_LAYER_READY, 1'b1, "layer_ready");
        repeat (8) @(negedge clk);
        if (out_req === 1'b1)
            received++;  // a stray entry left in the fifo
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (errors != errs_before)
            failed_tests++;
        $display("%s: %s (%0d errors)", name,
                 (errors == errs_before) ? "pass" : "fail", errors - errs_before);
    endtask

    task automatic run_pool_check(input string name, input int size, input int mode,
                                  input logic relu, input int max_delay);
        int errs_before;
        errs_before = errors;
        load_fm(size, mode);
        make_expected(size, relu);
        start_layer(size, relu);
        collect_outputs(max_delay);
        compare_count("results", received, exp_q.size());
        report_test(name, errs_before);
    endtask

    // cut a running layer with rst while start_ack and out_req are both high
    task automatic reset_mid_layer();
        int errs_before;
        errs_before = errors;
        load_fm(8, MODE_RANDOM);
        @(negedge clk);
        start_cfg.fm_size = 4'(8);
        start_cfg.relu_en = 1'b0;
        start_req = 1'b1;  // kept up so start_ack stays high into the reset
        wait_signal(SEL_START_ACK, 1'b1, "start_ack");
        wait_signal(SEL_OUT_REQ, 1'b1, "out_req");
        repeat (3) @(negedge clk);
        compare_bit("start_ack", start_ack, 1'b1);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        compare_bit("out_req", out_req, 1'b0);
        compare_bit("start_ack", start_ack, 1'b0);
        compare_bit("layer_ready", layer_ready, 1'b1);
        start_req = 1'b0;
        rst = 1'b0;
        @(negedge clk);
        compare_bit("out_req", out_req, 1'b0);     // fifo left empty
        compare_bit("layer_ready", layer_ready, 1'b1);
        report_test("reset_mid_layer", errs_before);
    endtask

    initial begin
        seed         = 32'haee;
        errors       = 0;
        test_count   = 0;
        failed_tests = 0;
        received     = 0;
        rst          = 1'b1;
        fm_wr_en     = 1'b0;
        fm_wr_row    = '0;
        fm_wr_col    = '0;
        fm_wr_data   = '0;
        start_req    = 1'b0;
        start_cfg    = '0;
        out_ack      = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        run_pool_check("positive_4x4", 4, MODE_POSITIVE, 1'b0, 0);
        run_pool_check("mixed_4x4", 4, MODE_MIXED, 1'b0, 0);
        run_pool_check("mixed_4x4_relu", 4, MODE_MIXED, 1'b1, 1);
        run_pool_check("random_8x8", 8, MODE_RANDOM, 1'b0, MAX_ACK_DELAY);
        run_pool_check("second_2x2", 2, MODE_RANDOM, 1'b1, 3);
        reset_mid_layer();
        run_pool_check("after_reset_8x8", 8, MODE_RANDOM, 1'b1, 2);

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cnn_pool_layer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cnn_defines.svh"

module cnn_pool_layer (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       fm_wr_en,
    input  wire logic [`FM_SIZE_WIDTH-1:0]  fm_wr_row,
    input  wire logic [`FM_SIZE_WIDTH-1:0]  fm_wr_col,
    input  wire layer_pkg::fm_pixel_t       fm_wr_data,
    input  wire logic                       start_req,
    input  wire layer_pkg::layer_cfg_t      start_cfg,
    output logic                            start_ack,
    output logic                            layer_ready,
    output logic                            out_req,
    input  wire logic                       out_ack,
    output layer_pkg::pool_result_t         out_data
);
    import layer_pkg::*;

    window_vec_t      windows;       // same window slot, one channel per lane
    lane_result_vec_t lane_results;
    logic hold;
    logic layer_end;
    logic relu_en;

    fm_window_feeder u_feeder (
        .clk         (clk),
        .rst         (rst),
        .fm_wr_en    (fm_wr_en),
        .fm_wr_row   (fm_wr_row),
        .fm_wr_col   (fm_wr_col),
        .fm_wr_data  (fm_wr_data),
        .start_req   (start_req),
        .start_cfg   (start_cfg),
        .hold        (hold),
        .layer_end   (layer_end),
        .start_ack   (start_ack),
        .layer_ready (layer_ready),
        .relu_en     (relu_en),
        .windows     (windows)
    );

    for (genvar l = 0; l < `PARA_LANES; l++) begin : g_lane
        pool_lane u_lane (
            .clk     (clk),
            .rst     (rst),
            .relu_en (relu_en),
            .window  (windows[l]),
            .result  (lane_results[l])
        );
    end

    result_drain u_drain (
        .clk          (clk),
        .rst          (rst),
        .issue        (windows[0].valid), // lanes share valid
        .lane_results (lane_results),
        .out_ack      (out_ack),
        .hold         (hold),
        .layer_end    (layer_end),
        .out_req      (out_req),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

// ==== logic/result_drain.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cnn_defines.svh"

module result_drain (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         issue,        // window valid from the feeder
    input  wire layer_pkg::lane_result_vec_t  lane_results,
    input  wire logic                         out_ack,
    output logic                              hold,
    output logic                              layer_end,
    output logic                              out_req,
    output layer_pkg::pool_result_t           out_data
);
    import layer_pkg::*;

    pool_result_t fifo_data [`DRAIN_DEPTH];
    logic fifo_last [`DRAIN_DEPTH];         // entry closes the layer
    logic [`DRAIN_PTR_WIDTH-1:0] wr_ptr;
    logic [`DRAIN_PTR_WIDTH-1:0] rd_ptr;
    logic [`DRAIN_CNT_WIDTH-1:0] occupancy;
    logic [`DRAIN_CNT_WIDTH-1:0] inflight;  // inside the lane pipes
    logic [`DRAIN_CNT_WIDTH:0] committed;   // slots spoken for
    logic push;
    logic pop;
    pool_result_t packed_entry;
    logic lanes_agree;

    assign push = lane_results[0].valid;
    assign pop  = out_req && out_ack;       // ack seen, transfer done

    // one entry from all lanes of one window
    always_comb begin
        packed_entry.out_row = lane_results[0].out_row;
        packed_entry.out_col = lane_results[0].out_col;
        lanes_agree          = 1'b1;
        for (int l = 0; l < `PARA_LANES; l++) begin
            packed_entry.values[l] = lane_results[l].value;
            if (lane_results[l].valid != lane_results[0].valid)
                lanes_agree = 1'b0;
        end
    end

    // window on the wire this cycle counts too
    assign committed = {1'b0, occupancy} + {1'b0, inflight} +
                       {{`DRAIN_CNT_WIDTH{1'b0}}, issue};
    assign hold      = committed >= (`DRAIN_CNT_WIDTH+1)'(`DRAIN_DEPTH);
    assign out_data  = fifo_data[rd_ptr]; // head is steady until pop

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_data[wr_ptr] <= packed_entry;
            fifo_last[wr_ptr] <= lane_results[0].last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            inflight  <= '0;
            out_req   <= 1'b0;
            layer_end <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: ;
            endcase
            case ({issue, push})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: ;
            endcase
            layer_end <= pop && fifo_last[rd_ptr];
            if (pop)
                out_req <= 1'b0;
            else if (!out_req && !out_ack && occupancy != '0)
                out_req <= 1'b1; // previous transfer back at zero
        end
    end

    // hold must leave room for everything already issued
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (push && !pop) |-> occupancy < `DRAIN_CNT_WIDTH'(`DRAIN_DEPTH))
        else $error("result fifo overflow");

    a_lanes_agree: assert property (@(posedge clk) disable iff (rst) lanes_agree)
        else $error("pool lanes disagree on valid");

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        (out_req && !out_ack) |=> $stable(out_data))
        else $error("out_data changed before out_ack");

endmodule

`default_nettype wire

// ==== logic/pool_lane.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cnn_defines.svh"

module pool_lane (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     relu_en,
    input  wire layer_pkg::pool_window_t  window,
    output layer_pkg::lane_result_t       result
);
    import fp16_pkg::*;

    // stage 1, row maxima
    logic s1_valid;
    logic s1_last;
    logic [`OUT_SIZE_WIDTH-1:0] s1_row;
    logic [`OUT_SIZE_WIDTH-1:0] s1_col;
    fp16_t s1_top;
    fp16_t s1_bot;

    // stage 2 inputs, before the register
    fp16_t s2_max;
    fp16_t s2_out;

    // sign magnitude max, +0 and -0 equal, ties keep a
    function automatic fp16_t fp16_max(input fp16_t a, input fp16_t b);
        logic [`DATA_WIDTH-2:0] a_mag;
        logic [`DATA_WIDTH-2:0] b_mag;
        logic b_wins;
        a_mag = {a.fields.exponent, a.fields.mantissa};
        b_mag = {b.fields.exponent, b.fields.mantissa};
        if (a_mag == '0 && b_mag == '0)
            b_wins = 1'b0;                 // both zero, sign ignored
        else if (a.fields.sign != b.fields.sign)
            b_wins = a.fields.sign;        // positive beats negative
        else if (a.fields.sign)
            b_wins = b_mag < a_mag;        // both negative, smaller magnitude wins
        else
            b_wins = b_mag > a_mag;
        return b_wins ? b : a;
    endfunction

    always_ff @(posedge clk) begin
        s1_last <= window.last;
        s1_row  <= window.out_row;
        s1_col  <= window.out_col;
        s1_top  <= fp16_max(window.tl, window.tr);
        s1_bot  <= fp16_max(window.bl, window.br);
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= window.valid;
    end

    always_comb begin
        s2_max = fp16_max(s1_top, s1_bot);
        if (relu_en && s2_max.fields.sign)
            s2_out = FP16_POS_ZERO; // -0 also lands here
        else
            s2_out = s2_max;
    end

    // stage 2, window max with optional relu
    always_ff @(posedge clk) begin
        result.last    <= s1_last;
        result.out_row <= s1_row;
        result.out_col <= s1_col;
        result.value   <= s2_out;
        if (rst)
            result.valid <= 1'b0;
        else
            result.valid <= s1_valid;
    end

endmodule

`default_nettype wire

// ==== logic/fm_window_feeder.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cnn_defines.svh"

module fm_window_feeder (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        fm_wr_en,
    input  wire logic [`FM_SIZE_WIDTH-1:0]   fm_wr_row,
    input  wire logic [`FM_SIZE_WIDTH-1:0]   fm_wr_col,
    input  wire layer_pkg::fm_pixel_t        fm_wr_data,
    input  wire logic                        start_req,
    input  wire layer_pkg::layer_cfg_t       start_cfg,
    input  wire logic                        hold,       // drain has no room left
    input  wire logic                        layer_end,  // last result acknowledged
    output logic                             start_ack,
    output logic                             layer_ready,
    output logic                             relu_en,
    output layer_pkg::window_vec_t           windows
);
    import layer_pkg::*;

    fm_pixel_t fm_mem [`FM_SIZE_MAX][`FM_SIZE_MAX]; // row, col

    layer_cfg_t cfg;                         // latched at start
    logic issuing;                           // windows still to go
    logic [`OUT_SIZE_WIDTH-1:0] row_cnt;     // pooled row being issued
    logic [`OUT_SIZE_WIDTH-1:0] col_cnt;     // pooled column being issued
    logic [`FM_SIZE_WIDTH-1:0] out_last_idx; // fm_size/2 - 1
    logic last_col;
    logic last_pos;
    logic start_take;

    // map coordinates of the current 2x2 window
    logic [`FM_SIZE_WIDTH-1:0] top_row;
    logic [`FM_SIZE_WIDTH-1:0] bot_row;
    logic [`FM_SIZE_WIDTH-1:0] left_col;
    logic [`FM_SIZE_WIDTH-1:0] right_col;

    // registered window, shared by all lanes
    logic win_valid;
    logic win_last;
    logic [`OUT_SIZE_WIDTH-1:0] win_row;
    logic [`OUT_SIZE_WIDTH-1:0] win_col;
    fm_pixel_t px_tl;
    fm_pixel_t px_tr;
    fm_pixel_t px_bl;
    fm_pixel_t px_br;

    assign relu_en      = cfg.relu_en;
    assign out_last_idx = cfg.fm_size[`FM_SIZE_WIDTH:1] - 1'b1;
    assign last_col     = col_cnt == out_last_idx[`OUT_SIZE_WIDTH-1:0];
    assign last_pos     = last_col && (row_cnt == out_last_idx[`OUT_SIZE_WIDTH-1:0]);
    assign start_take   = layer_ready && start_req && !start_ack; // new request while idle

    assign top_row   = {row_cnt, 1'b0};
    assign bot_row   = {row_cnt, 1'b1};
    assign left_col  = {col_cnt, 1'b0};
    assign right_col = {col_cnt, 1'b1};

    // host load, only taken while idle
    always_ff @(posedge clk) begin
        if (fm_wr_en && layer_ready)
            fm_mem[fm_wr_row][fm_wr_col] <= fm_wr_data;
    end

    // start handshake, layer state and window counters
    always_ff @(posedge clk) begin
        if (rst) begin
            start_ack   <= 1'b0;
            layer_ready <= 1'b1;
            issuing     <= 1'b0;
            cfg         <= '0;
            row_cnt     <= '0;
            col_cnt     <= '0;
        end else begin
            if (start_take) begin
                start_ack   <= 1'b1;
                layer_ready <= 1'b0;
                issuing     <= 1'b1;
                cfg         <= start_cfg;
                row_cnt     <= '0;
                col_cnt     <= '0;
            end else if (start_ack && !start_req) begin
                start_ack <= 1'b0; // return to zero
            end
            if (issuing && !hold) begin
                if (last_col) begin
                    col_cnt <= '0;
                    if (last_pos)
                        issuing <= 1'b0; // final window goes out now
                    else
                        row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            if (layer_end)
                layer_ready <= 1'b1;
        end
    end

    // window register, valid under reset, pixels free running
    always_ff @(posedge clk) begin
        win_last <= last_pos;
        win_row  <= row_cnt;
        win_col  <= col_cnt;
        px_tl    <= fm_mem[top_row][left_col];
        px_tr    <= fm_mem[top_row][right_col];
        px_bl    <= fm_mem[bot_row][left_col];
        px_br    <= fm_mem[bot_row][right_col];
        if (rst)
            win_valid <= 1'b0;
        else
            win_valid <= issuing && !hold;
    end

    // split the four pixels by channel
    always_comb begin
        for (int l = 0; l < `PARA_LANES; l++) begin
            windows[l].valid   = win_valid;
            windows[l].last    = win_last;
            windows[l].out_row = win_row;
            windows[l].out_col = win_col;
            windows[l].tl      = px_tl[l];
            windows[l].tr      = px_tr[l];
            windows[l].bl      = px_bl[l];
            windows[l].br      = px_br[l];
        end
    end

    // the host must not touch the map while a layer runs
    a_no_write_busy: assert property (@(posedge clk) disable iff (rst)
        fm_wr_en |-> layer_ready)
        else $error("feature map write while layer busy");

    // odd or oversized maps would leave windows half outside the map
    a_cfg_size: assert property (@(posedge clk) disable iff (rst)
        start_take |-> (!start_cfg.fm_size[0] && start_cfg.fm_size != '0 &&
                        start_cfg.fm_size <= (`FM_SIZE_WIDTH+1)'(`FM_SIZE_MAX)))
        else $error("bad fm_size at start");

endmodule

`default_nettype wire

// ==== logic/layer_pkg.sv ====
`default_nettype none

`include "cnn_defines.svh"

// layer level bundles between host, feeder, lanes and drain
package layer_pkg;

    // start word, sampled with start_req
    typedef struct packed {
        logic [`FM_SIZE_WIDTH:0] fm_size; // map edge, even, 2 .. 8
        logic                    relu_en; // clamp negative maxima to +0
    } layer_cfg_t;

    // one pixel, all channels, lane 0 in the low word
    typedef fp16_pkg::fp16_t [`PARA_LANES-1:0] fm_pixel_t;

    // 2x2 window of a single channel, handed to one lane
    typedef struct packed {
        logic                       valid;
        logic                       last;    // final window of the layer
        logic [`OUT_SIZE_WIDTH-1:0] out_row;
        logic [`OUT_SIZE_WIDTH-1:0] out_col;
        fp16_pkg::fp16_t            tl;      // top left
        fp16_pkg::fp16_t            tr;      // top right
        fp16_pkg::fp16_t            bl;      // bottom left
        fp16_pkg::fp16_t            br;      // bottom right
    } pool_window_t;

    typedef pool_window_t [`PARA_LANES-1:0] window_vec_t;

    // pooled value of one channel, two cycles behind its window
    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic [`OUT_SIZE_WIDTH-1:0] out_row;
        logic [`OUT_SIZE_WIDTH-1:0] out_col;
        fp16_pkg::fp16_t            value;
    } lane_result_t;

    typedef lane_result_t [`PARA_LANES-1:0] lane_result_vec_t;

    // pooled pixel as it leaves on the output port
    typedef struct packed {
        logic [`OUT_SIZE_WIDTH-1:0] out_row;
        logic [`OUT_SIZE_WIDTH-1:0] out_col;
        fm_pixel_t                  values;  // lane order as fm_pixel_t
    } pool_result_t;

endpackage

`default_nettype wire

// ==== logic/fp16_pkg.sv ====
`default_nettype none

`include "cnn_defines.svh"

// ieee half precision as the lanes see it
package fp16_pkg;

    // sign, biased exponent and fraction of one half word
    typedef struct packed {
        logic                        sign;     // 1 means negative
        logic [`FP16_EXP_WIDTH-1:0]  exponent; // bias 15
        logic [`FP16_MAN_WIDTH-1:0]  mantissa; // hidden bit not stored
    } fp16_fields_t;

    // one float16 word, readable either as plain bits or as its fields
    // memory and host side use raw, the max compare and relu use fields
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;
        fp16_fields_t           fields;
    } fp16_t;

    // relu output for any negative input, -0 included
    localparam fp16_t FP16_POS_ZERO = '0;

endpackage

`default_nettype wire

// ==== logic/cnn_defines.svh ====
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// channels pooled side by side, one pool lane each
`define PARA_LANES 4

// float16 word and its fields
`define DATA_WIDTH 16
`define FP16_EXP_WIDTH 5
`define FP16_MAN_WIDTH 10

// feature map geometry
`define FM_SIZE_MAX 8      // largest map edge in pixels
`define FM_SIZE_WIDTH 3    // bits of a map row or column
`define OUT_SIZE_WIDTH 2   // bits of a pooled row or column

// result fifo in front of the output port
`define DRAIN_DEPTH 4
`define DRAIN_PTR_WIDTH 2  // log2 of the depth
`define DRAIN_CNT_WIDTH 3  // holds 0 .. depth

`endif
